/* src/rv_core_settings.svh */
// =========================================================================
// RV32I core settings
// Datapath width, register file size and the pipeline bubble encoding
// =========================================================================

`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Datapath width in bits
`define RV_W_DATA 32

// Architectural register count and index width
`define RV_N_REGS 32
`define RV_W_REGADDR 5

// ADDI x0, x0, 0
`define RV_NOP_INSTR 32'h0000_0013

`endif

/* src/rv_core_pkg.sv */
// =========================================================================
// RV32I core types
// Data words, register indices and the decode enums shared by all stages
// =========================================================================

`include "rv_core_settings.svh"
`default_nettype none

package rv_core_pkg;

	typedef logic [`RV_W_DATA-1:0] data_t;
	typedef logic [`RV_W_REGADDR-1:0] regaddr_t;
	typedef logic [31:0] instr_t;

	// Major opcodes kept by this core
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111
	} opcode_e;

	// ALU operations, low bits follow funct3 and bit 3 follows funct7[5]
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SLL = 4'h1,
		LT  = 4'h2,
		LTU = 4'h3,
		XOR = 4'h4,
		SRL = 4'h5,
		OR  = 4'h6,
		AND = 4'h7,
		SUB = 4'h8,
		SRA = 4'hd
	} alu_op_e;

	typedef enum logic {
		RS1  = 1'b0,
		ZERO = 1'b1
	} alusrc_a_e;

	typedef enum logic {
		RS2 = 1'b0,
		IMM = 1'b1
	} alusrc_b_e;

endpackage

`default_nettype wire

/* src/rv_dx_if.sv */
// =========================================================================
// Decode to execute pipeline register
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

interface rv_dx_if;
	import rv_core_pkg::*;

	// Register operands and destination, zero for a bubble
	regaddr_t  rs1;
	regaddr_t  rs2;
	regaddr_t  rd;

	// Operation and operand selection
	data_t     imm;
	alu_op_e   alu_op;
	alusrc_a_e src_a;
	alusrc_b_e src_b;

	// Instruction was not recognised
	logic      illegal;

	modport producer (
		output rs1, rs2, rd, imm, alu_op, src_a, src_b, illegal
	);

	modport consumer (
		input rs1, rs2, rd, imm, alu_op, src_a, src_b, illegal
	);

endinterface

`default_nettype wire

/* src/rv_alu.sv */
// =========================================================================
// RV32I ALU
// Add, subtract, logic, compares and shifts
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

module rv_alu (
	input  wire rv_core_pkg::alu_op_e  alu_op_i,
	input  wire rv_core_pkg::data_t    op_a_i,
	input  wire rv_core_pkg::data_t    op_b_i,
	output rv_core_pkg::data_t         result_o
);
	import rv_core_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// Shift amount is the low five bits of B
	assign shamt = op_b_i[4:0];

	assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
	assign lt_unsigned = op_a_i < op_b_i;

	always_comb begin
		case (alu_op_i)
			ADD:     result_o = op_a_i + op_b_i;
			SUB:     result_o = op_a_i - op_b_i;
			SLL:     result_o = op_a_i << shamt;
			LT:      result_o = data_t'(lt_signed);
			LTU:     result_o = data_t'(lt_unsigned);
			XOR:     result_o = op_a_i ^ op_b_i;
			SRL:     result_o = op_a_i >> shamt;
			SRA:     result_o = data_t'($signed(op_a_i) >>> shamt);
			OR:      result_o = op_a_i | op_b_i;
			AND:     result_o = op_a_i & op_b_i;
			default: result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/rv_decode_stage.sv */
// =========================================================================
// Decode stage
// Turns one RV32I OP, OP-IMM or LUI word per cycle into datapath controls
// =========================================================================

`timescale 1ns/1ns
`include "rv_core_settings.svh"
`default_nettype none

module rv_decode_stage (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire rv_core_pkg::instr_t   instr_i,
	input  wire                        instr_vld_i,
	output rv_core_pkg::regaddr_t      rs1_addr_o,
	output rv_core_pkg::regaddr_t      rs2_addr_o,
	rv_dx_if.producer                  dx
);
	import rv_core_pkg::*;

	instr_t     d_instr;
	opcode_e    d_opcode;
	logic [2:0] d_funct3;
	logic [6:0] d_funct7;
	data_t      d_imm_i;
	data_t      d_imm_u;

	data_t      d_imm;
	alu_op_e    d_alu_op;
	alusrc_a_e  d_src_a;
	alusrc_b_e  d_src_b;
	logic       d_legal;

	// Map funct3 onto an ALU operation, alt picks SUB or SRA
	function automatic alu_op_e funct3_op(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'b000:  funct3_op = alt ? SUB : ADD;
			3'b001:  funct3_op = SLL;
			3'b010:  funct3_op = LT;
			3'b011:  funct3_op = LTU;
			3'b100:  funct3_op = XOR;
			3'b101:  funct3_op = alt ? SRA : SRL;
			3'b110:  funct3_op = OR;
			default: funct3_op = AND;
		endcase
	endfunction

	// Idle cycles decode as the canonical NOP, which is a bubble
	assign d_instr  = instr_vld_i ? instr_i : `RV_NOP_INSTR;
	assign d_opcode = opcode_e'(d_instr[6:0]);
	assign d_funct3 = d_instr[14:12];
	assign d_funct7 = d_instr[31:25];

	assign d_imm_i = {{20{d_instr[31]}}, d_instr[31:20]};
	assign d_imm_u = {d_instr[31:12], 12'h000};

	// Register file is read in parallel with decode
	assign rs1_addr_o = d_instr[19:15];
	assign rs2_addr_o = d_instr[24:20];

	always_comb begin
		d_imm    = d_imm_i;
		d_alu_op = ADD;
		d_src_a  = RS1;
		d_src_b  = RS2;
		d_legal  = 1'b0;
		case (d_opcode)
			OP: begin
				d_alu_op = funct3_op(d_funct3, d_funct7[5]);
				d_legal  = (d_funct7 == 7'b0000000) ||
					(d_funct7 == 7'b0100000 && (d_funct3 == 3'b000 || d_funct3 == 3'b101));
			end
			OP_IMM: begin
				d_src_b = IMM;
				// Bit 30 only means something for right shifts
				d_alu_op = funct3_op(d_funct3, d_funct3 == 3'b101 && d_funct7[5]);
				case (d_funct3)
					3'b001:  d_legal = d_funct7 == 7'b0000000;
					3'b101:  d_legal = d_funct7 == 7'b0000000 || d_funct7 == 7'b0100000;
					default: d_legal = 1'b1;
				endcase
			end
			LUI: begin
				d_imm   = d_imm_u;
				d_src_a = ZERO;
				d_src_b = IMM;
				d_legal = 1'b1;
			end
			default: d_legal = 1'b0;
		endcase
	end

	// =====================================================================
	// D to X register
	// =====================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx.rs1     <= '0;
			dx.rs2     <= '0;
			dx.rd      <= '0;
			dx.alu_op  <= ADD;
			dx.src_a   <= RS1;
			dx.src_b   <= RS2;
			dx.illegal <= 1'b0;
		end else begin
			dx.rs1     <= d_instr[19:15];
			dx.rs2     <= d_instr[24:20];
			// Unrecognised words retire without a write
			dx.rd      <= d_legal ? d_instr[11:7] : '0;
			dx.alu_op  <= d_alu_op;
			dx.src_a   <= d_src_a;
			dx.src_b   <= d_src_b;
			dx.illegal <= !d_legal;
		end
	end

	always_ff @(posedge clk) begin
		dx.imm <= d_imm;
	end

endmodule

`default_nettype wire

/* src/rv_regfile.sv */
// =========================================================================
// Register file
// One write port and two read ports, read data registered
// =========================================================================

`timescale 1ns/1ns
`include "rv_core_settings.svh"
`default_nettype none

module rv_regfile #(
	parameter int N_REGS = `RV_N_REGS
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire rv_core_pkg::regaddr_t   raddr1_i,
	input  wire rv_core_pkg::regaddr_t   raddr2_i,
	output rv_core_pkg::data_t           rdata1_o,
	output rv_core_pkg::data_t           rdata2_o,
	input  wire rv_core_pkg::regaddr_t   waddr_i,
	input  wire rv_core_pkg::data_t      wdata_i,
	input  wire                          wen_i
);
	import rv_core_pkg::*;

	data_t regs [N_REGS];

	// Reads sample the array before this edge's write lands
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < N_REGS; i++) begin
				regs[i] <= '0;
			end
			rdata1_o <= '0;
			rdata2_o <= '0;
		end else begin
			rdata1_o <= regs[raddr1_i];
			rdata2_o <= regs[raddr2_i];
			// x0 is never enabled by the execute stage
			if (wen_i) begin
				regs[waddr_i] <= wdata_i;
			end
		end
	end

endmodule

`default_nettype wire

/* src/rv_execute_stage.sv */
// =========================================================================
// Execute stage
// Operand bypass and ALU, result held in the retire register
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

module rv_execute_stage (
	input  wire                        clk,
	input  wire                        rst_n,
	rv_dx_if.consumer                  dx,
	input  wire rv_core_pkg::data_t    rdata1_i,
	input  wire rv_core_pkg::data_t    rdata2_i,
	output logic                       wb_en_o,
	output rv_core_pkg::regaddr_t      wb_rd_o,
	output rv_core_pkg::data_t         wb_data_o,
	output logic                       illegal_o
);
	import rv_core_pkg::*;

	// Retire register, also the register file write port
	logic     xw_en;
	regaddr_t xw_rd;
	data_t    xw_result;
	logic     xw_illegal;

	// Write that reached the register file on the last edge
	regaddr_t pw_rd;
	data_t    pw_result;

	data_t    rs1_val;
	data_t    rs2_val;
	data_t    op_a;
	data_t    op_b;
	data_t    alu_result;

	// A zero rd never matches a nonzero source, so bubbles need no valid bit
	function automatic data_t bypass(input regaddr_t rs, input data_t rf_data);
		if (rs == '0) begin
			bypass = '0;
		end else if (rs == xw_rd) begin
			bypass = xw_result;
		end else if (rs == pw_rd) begin
			// Register file read missed this write by one edge
			bypass = pw_result;
		end else begin
			bypass = rf_data;
		end
	endfunction

	always_comb begin
		rs1_val = bypass(dx.rs1, rdata1_i);
		rs2_val = bypass(dx.rs2, rdata2_i);
		op_a    = (dx.src_a == ZERO) ? '0 : rs1_val;
		op_b    = (dx.src_b == IMM) ? dx.imm : rs2_val;
	end

	rv_alu u_alu (
		.alu_op_i (dx.alu_op),
		.op_a_i   (op_a),
		.op_b_i   (op_b),
		.result_o (alu_result)
	);

	// =====================================================================
	// Retire and previous-write registers
	// =====================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xw_en      <= 1'b0;
			xw_rd      <= '0;
			xw_result  <= '0;
			xw_illegal <= 1'b0;
			pw_rd      <= '0;
		end else begin
			xw_en      <= |dx.rd;
			xw_rd      <= dx.rd;
			xw_result  <= alu_result;
			xw_illegal <= dx.illegal;
			pw_rd      <= xw_rd;
		end
	end

	always_ff @(posedge clk) begin
		pw_result <= xw_result;
	end

	assign wb_en_o   = xw_en;
	assign wb_rd_o   = xw_rd;
	assign wb_data_o = xw_result;
	assign illegal_o = xw_illegal;

endmodule

`default_nettype wire

/* src/rv_core_top.sv */
// =========================================================================
// RV32I integer core
// Decode, register file and execute, one retire per instruction
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

module rv_core_top (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire rv_core_pkg::instr_t   instr_i,
	input  wire                        instr_vld_i,
	output wire                        wb_en_o,
	output wire rv_core_pkg::regaddr_t wb_rd_o,
	output wire rv_core_pkg::data_t    wb_data_o,
	output wire                        illegal_o
);
	import rv_core_pkg::*;

	regaddr_t rs1_addr;
	regaddr_t rs2_addr;
	data_t    rdata1;
	data_t    rdata2;

	rv_dx_if u_dx_if ();

	rv_decode_stage u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_i     (instr_i),
		.instr_vld_i (instr_vld_i),
		.rs1_addr_o  (rs1_addr),
		.rs2_addr_o  (rs2_addr),
		.dx          (u_dx_if.producer)
	);

	// Write port is fed straight from the retire register
	rv_regfile u_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.waddr_i  (wb_rd_o),
		.wdata_i  (wb_data_o),
		.wen_i    (wb_en_o)
	);

	rv_execute_stage u_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.dx        (u_dx_if.consumer),
		.rdata1_i  (rdata1),
		.rdata2_i  (rdata2),
		.wb_en_o   (wb_en_o),
		.wb_rd_o   (wb_rd_o),
		.wb_data_o (wb_data_o),
		.illegal_o (illegal_o)
	);

endmodule

`default_nettype wire

/* tb/rv_core_chk.sv */
// =========================================================================
// RV32I core output checks
// Assertions on the retire outputs, bound to the core top level
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

module rv_core_chk (
	input wire                        clk,
	input wire                        rst_n,
	input wire                        wb_en_i,
	input wire rv_core_pkg::regaddr_t wb_rd_i,
	input wire rv_core_pkg::data_t    wb_data_i,
	input wire                        illegal_i
);

	// A write always names a real register
	a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		wb_en_i |-> wb_rd_i != '0)
		else $error("wb_en_o high with wb_rd_o equal to x0");

	// An illegal instruction never writes
	a_en_ill_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_en_i && illegal_i))
		else $error("wb_en_o and illegal_o high in the same cycle");

	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> (!wb_en_i && !illegal_i && wb_rd_i == '0 && wb_data_i == '0))
		else $error("core outputs not zero during reset");

endmodule

bind rv_core_top rv_core_chk u_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.wb_en_i   (wb_en_o),
	.wb_rd_i   (wb_rd_o),
	.wb_data_i (wb_data_o),
	.illegal_i (illegal_o)
);

`default_nettype wire

/* tb/tb_rv_core.sv */
// =========================================================================
// RV32I core testbench
// Table-driven instruction stream with in-order retire checks
// =========================================================================

`timescale 1ns/1ns
`include "rv_core_settings.svh"
`default_nettype none

module tb_rv_core;
	import rv_core_pkg::*;

	localparam int MAX_ENTRIES = 48;
	// Gap value that asks for a random idle count
	localparam int RND = -1;

	logic     clk;
	logic     rst_n;
	instr_t   instr;
	logic     instr_vld;
	logic     wb_en;
	regaddr_t wb_rd;
	data_t    wb_data;
	logic     illegal;

	// Stimulus table
	string    t_name  [MAX_ENTRIES];
	instr_t   t_instr [MAX_ENTRIES];
	int       t_gap   [MAX_ENTRIES];
	int       t_rd    [MAX_ENTRIES];
	data_t    t_value [MAX_ENTRIES];
	bit       t_ill   [MAX_ENTRIES];
	int       n_entries = 0;
	logic     table_built = 1'b0;

	// Table indices still waiting to retire
	int       exp_q [$];
	integer   seed = 87;

	rv_core_top u_rv_core_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_i     (instr),
		.instr_vld_i (instr_vld),
		.wb_en_o     (wb_en),
		.wb_rd_o     (wb_rd),
		.wb_data_o   (wb_data),
		.illegal_o   (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// RV32I instruction formats
	function automatic instr_t enc_r(input int funct7, input int funct3, input int rd,
			input int rs1, input int rs2);
		return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic instr_t enc_i(input int funct3, input int rd, input int rs1,
			input int imm);
		return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0010011};
	endfunction

	function automatic instr_t enc_lui(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic void add_entry(input string name, input instr_t word, input int gap,
			input int rd, input data_t value, input bit ill);
		t_name[n_entries]  = name;
		t_instr[n_entries] = word;
		t_gap[n_entries]   = gap;
		t_rd[n_entries]    = rd;
		t_value[n_entries] = value;
		t_ill[n_entries]   = ill;
		n_entries++;
	endfunction

	// =====================================================================
	// Stimulus table where each expected value follows from the entries above it
	// =====================================================================

	function automatic void build_table();
		// Immediate ops on a freshly reset register file
		add_entry("addi_pos", enc_i(0, 1, 0, 100), RND, 1, 32'h0000_0064, 0);
		add_entry("addi_neg", enc_i(0, 2, 0, -1), RND, 2, 32'hffff_ffff, 0);
		add_entry("xori", enc_i(4, 3, 2, 'h555), RND, 3, 32'hffff_faaa, 0);
		add_entry("ori", enc_i(6, 4, 1, 'h700), RND, 4, 32'h0000_0764, 0);
		add_entry("andi", enc_i(7, 5, 2, 'h0f0), RND, 5, 32'h0000_00f0, 0);
		add_entry("slti", enc_i(2, 6, 2, 0), RND, 6, 32'h0000_0001, 0);
		add_entry("sltiu", enc_i(3, 7, 1, -1), RND, 7, 32'h0000_0001, 0);
		add_entry("slli", enc_i(1, 8, 1, 4), RND, 8, 32'h0000_0640, 0);
		add_entry("lui", enc_lui(11, 'h80000), RND, 11, 32'h8000_0000, 0);
		add_entry("srli", enc_i(5, 9, 11, 4), RND, 9, 32'h0800_0000, 0);
		add_entry("srai", enc_i(5, 10, 11, 'h404), RND, 10, 32'hf800_0000, 0);
		// Register-register ops
		add_entry("add", enc_r(0, 0, 12, 1, 8), RND, 12, 32'h0000_06a4, 0);
		add_entry("sub", enc_r('h20, 0, 13, 1, 8), RND, 13, 32'hffff_fa24, 0);
		add_entry("sll", enc_r(0, 1, 14, 1, 5), RND, 14, 32'h0064_0000, 0);
		add_entry("slt_neg", enc_r(0, 2, 15, 11, 1), RND, 15, 32'h0000_0001, 0);
		add_entry("sltu_neg", enc_r(0, 3, 16, 11, 1), RND, 16, 32'h0000_0000, 0);
		add_entry("xor", enc_r(0, 4, 17, 3, 2), RND, 17, 32'h0000_0555, 0);
		add_entry("srl", enc_r(0, 5, 18, 10, 6), RND, 18, 32'h7c00_0000, 0);
		add_entry("sra", enc_r('h20, 5, 19, 10, 6), RND, 19, 32'hfc00_0000, 0);
		add_entry("or", enc_r(0, 6, 20, 4, 5), RND, 20, 32'h0000_07f4, 0);
		add_entry("and", enc_r(0, 7, 21, 3, 4), RND, 21, 32'h0000_0220, 0);
		// Dependent chain on back-to-back slots
		add_entry("byp_src", enc_i(0, 22, 0, 7), RND, 22, 32'h0000_0007, 0);
		add_entry("byp_1slot", enc_i(0, 23, 22, 1), 0, 23, 32'h0000_0008, 0);
		add_entry("byp_2slot", enc_r(0, 0, 24, 22, 23), 0, 24, 32'h0000_000f, 0);
		add_entry("byp_3slot", enc_r(0, 0, 25, 22, 24), 0, 25, 32'h0000_0016, 0);
		add_entry("byp_sub", enc_r('h20, 0, 26, 23, 25), 0, 26, 32'hffff_fff2, 0);
		add_entry("byp_rs2_2slot", enc_r(0, 0, 27, 0, 25), 0, 27, 32'h0000_0016, 0);
		add_entry("byp_redef", enc_i(0, 22, 22, 100), RND, 22, 32'h0000_006b, 0);
		add_entry("byp_newest", enc_i(0, 28, 22, 0), 0, 28, 32'h0000_006b, 0);
		// Writes to x0 retire silently
		add_entry("x0_addi", enc_i(0, 0, 1, 5), RND, 0, 32'h0000_0000, 0);
		add_entry("x0_read", enc_r(0, 0, 29, 0, 1), 0, 29, 32'h0000_0064, 0);
		add_entry("x0_lui", enc_lui(0, 'habcde), 0, 0, 32'h0000_0000, 0);
		add_entry("x0_after_lui", enc_i(0, 30, 0, 'h123), 0, 30, 32'h0000_0123, 0);
		// lw x1, 0(x2) then beq x1, x1, 8 then c.li x10, 1 then mul x9, x1, x1
		add_entry("ill_load", 32'h0001_2083, RND, 0, 32'h0000_0000, 1);
		add_entry("ill_branch", 32'h0010_8463, RND, 0, 32'h0000_0000, 1);
		add_entry("ill_compressed", 32'h0000_4505, RND, 0, 32'h0000_0000, 1);
		add_entry("ill_mul", enc_r(1, 0, 9, 1, 1), RND, 0, 32'h0000_0000, 1);
		add_entry("ill_keep_x1_x10", enc_r(0, 0, 31, 1, 10), RND, 31, 32'hf800_0064, 0);
		add_entry("ill_keep_x8_x9", enc_r(0, 0, 26, 8, 9), 0, 26, 32'h0800_0640, 0);
	endfunction

	task automatic fail_run;
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_value(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s %s expected 0x%08h actual 0x%08h",
				test, field, expected, actual);
			fail_run();
		end
	endtask

	// Idle cycles first and then a one-cycle strobe
	task automatic apply_entry(input int idx);
		int gap;
		gap = t_gap[idx];
		if (gap < 0) begin
			gap = $random(seed) % 3;
			if (gap < 0) begin
				gap = -gap;
			end
		end
		repeat (gap) begin
			@(posedge clk);
			#1;
			instr     = `RV_NOP_INSTR;
			instr_vld = 1'b0;
		end
		@(posedge clk);
		#1;
		instr     = t_instr[idx];
		instr_vld = 1'b1;
		if (t_ill[idx] || t_rd[idx] != 0) begin
			exp_q.push_back(idx);
		end
	endtask

	// =====================================================================
	// Main sequence, retire monitor and watchdog
	// =====================================================================

	initial begin : stimulus
		int idx;
		rst_n     = 1'b1;
		instr     = `RV_NOP_INSTR;
		instr_vld = 1'b0;
		build_table();
		table_built = 1'b1;
		#1 rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		for (idx = 0; idx < n_entries; idx++) begin
			apply_entry(idx);
		end
		@(posedge clk);
		#1;
		instr     = `RV_NOP_INSTR;
		instr_vld = 1'b0;
		// Last strobe retires two edges later with margin to spare
		repeat (4) @(posedge clk);
		#1;
		if (exp_q.size() != 0) begin
			$display("Run ended with %0d instructions that never retired", exp_q.size());
			fail_run();
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin : monitor
		int idx;
		if (rst_n && (wb_en || illegal)) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected retire on rd %0d while no instruction was outstanding",
					wb_rd);
				fail_run();
			end else begin
				idx = exp_q.pop_front();
				check_value(t_name[idx], "illegal", 32'(t_ill[idx]), 32'(illegal));
				check_value(t_name[idx], "wb_en", 32'(t_rd[idx] != 0 && !t_ill[idx]),
					32'(wb_en));
				check_value(t_name[idx], "rd", t_rd[idx], 32'(wb_rd));
				if (!t_ill[idx]) begin
					check_value(t_name[idx], "data", t_value[idx], wb_data);
				end
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (table_built);
		limit = n_entries * 4 + 40;
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		fail_run();
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/rv_core_pkg.sv
src/rv_dx_if.sv
src/rv_alu.sv
src/rv_decode_stage.sv
src/rv_regfile.sv
src/rv_execute_stage.sv
src/rv_core_top.sv
tb/rv_core_chk.sv
tb/tb_rv_core.sv

/* Makefile */
# Verilator build and run for the RV32I core testbench

TOOL      = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP       = tb_rv_core
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The simulator output goes to the log, and the pass line decides the status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
